// File: filelist.f
hw/tlp_pkg.sv
hw/stat_pkg.sv
hw/tlp_stat_monitor.sv
hw/stat_arb_mux.sv
hw/stat_counter_bank.sv
hw/stat_wb_regs.sv
hw/tlp_stats_top.sv
test/tb_tlp_stats.sv

// File: hw/stat_arb_mux.sv
module stat_arb_mux (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [stat_pkg::STAT_IDX_WIDTH-1:0]  in_idx [stat_pkg::STAT_CH_COUNT],
    input  logic [stat_pkg::STAT_INC_WIDTH-1:0]  in_inc [stat_pkg::STAT_CH_COUNT],
    input  logic [stat_pkg::STAT_CH_COUNT-1:0]   in_valid,
    output logic [stat_pkg::STAT_CH_COUNT-1:0]   in_ready,
    output logic [stat_pkg::STAT_ID_WIDTH-1:0]   stat_id,
    output logic [stat_pkg::STAT_INC_WIDTH-1:0]  stat_inc,
    output logic                                 stat_valid,
    input  logic                                 stat_ready
);
    import stat_pkg::*;

    logic [STAT_CH_WIDTH-1:0] last_ch;
    logic [STAT_CH_WIDTH-1:0] grant_ch;
    logic                     grant_any;
    logic                     out_free;

    assign out_free = !stat_valid || stat_ready;

    // Search starts at the channel after the last grant
    always_comb begin
        int ch;
        grant_any = 1'b0;
        grant_ch = '0;
        for (int k = STAT_CH_COUNT; k >= 1; k--) begin
            ch = (int'(last_ch) + k) % STAT_CH_COUNT;
            if (in_valid[ch]) begin
                grant_any = 1'b1;
                grant_ch = STAT_CH_WIDTH'(ch);
            end
        end
        for (int i = 0; i < STAT_CH_COUNT; i++) begin
            in_ready[i] = out_free && grant_any && (grant_ch == STAT_CH_WIDTH'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stat_valid <= 1'b0;
            last_ch <= STAT_CH_WIDTH'(STAT_CH_COUNT - 1);
        end else if (out_free) begin
            stat_valid <= grant_any;
            if (grant_any) begin
                last_ch <= grant_ch;
            end
        end
    end

    // Channel number becomes the upper half of the id
    always_ff @(posedge clk) begin
        if (out_free && grant_any) begin
            stat_id <= {grant_ch, in_idx[grant_ch]};
            stat_inc <= in_inc[grant_ch];
        end
    end

    // A waiting monitor keeps its request up until it is granted
    assert property (@(posedge clk) disable iff (reset)
        ($past(in_valid & ~in_ready) & ~in_valid) == '0)
    else $error("monitor request withdrawn before grant");

endmodule

// File: hw/stat_counter_bank.sv
module stat_counter_bank (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [stat_pkg::STAT_ID_WIDTH-1:0]   stat_id,
    input  logic [stat_pkg::STAT_INC_WIDTH-1:0]  stat_inc,
    input  logic                                 stat_valid,
    output logic                                 stat_ready,
    input  logic                                 cnt_enable,
    input  logic                                 cnt_clear,
    input  logic [stat_pkg::STAT_ID_WIDTH-1:0]   rd_id,
    output logic [stat_pkg::STAT_CNT_WIDTH-1:0]  rd_data
);
    import stat_pkg::*;

    logic [STAT_CNT_WIDTH-1:0] cnt [STAT_CH_COUNT][STAT_IDX_COUNT];
    logic                      pipe_valid;
    logic [STAT_ID_WIDTH-1:0]  pipe_id;
    logic [STAT_INC_WIDTH-1:0] pipe_inc;
    logic [STAT_CH_WIDTH-1:0]  pipe_ch;
    logic [STAT_IDX_WIDTH-1:0] pipe_idx;
    logic [STAT_CH_WIDTH-1:0]  rd_ch;
    logic [STAT_IDX_WIDTH-1:0] rd_idx;

    // Stalled while frozen and during the clear cycle
    assign stat_ready = cnt_enable && !cnt_clear;

    assign pipe_ch = pipe_id[STAT_ID_WIDTH-1 -: STAT_CH_WIDTH];
    assign pipe_idx = pipe_id[STAT_IDX_WIDTH-1:0];
    assign rd_ch = rd_id[STAT_ID_WIDTH-1 -: STAT_CH_WIDTH];
    assign rd_idx = rd_id[STAT_IDX_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            pipe_valid <= 1'b0;
        end else begin
            pipe_valid <= stat_valid && stat_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (stat_valid && stat_ready) begin
            pipe_id <= stat_id;
            pipe_inc <= stat_inc;
        end
    end

    // Counters wrap at 32 bits
    always_ff @(posedge clk) begin
        if (reset || cnt_clear) begin
            for (int c = 0; c < STAT_CH_COUNT; c++) begin
                for (int i = 0; i < STAT_IDX_COUNT; i++) begin
                    cnt[c][i] <= '0;
                end
            end
        end else if (pipe_valid && int'(pipe_ch) < STAT_CH_COUNT
                     && int'(pipe_idx) < STAT_IDX_COUNT) begin
            cnt[pipe_ch][pipe_idx] <= cnt[pipe_ch][pipe_idx] + STAT_CNT_WIDTH'(pipe_inc);
        end
    end

    always_comb begin
        if (int'(rd_ch) < STAT_CH_COUNT && int'(rd_idx) < STAT_IDX_COUNT) begin
            rd_data = cnt[rd_ch][rd_idx];
        end else begin
            rd_data = '0;
        end
    end

    // Entry from the arbiter is held while the bank stalls
    assert property (@(posedge clk) disable iff (reset)
        stat_valid && !stat_ready |=> stat_valid && $stable(stat_id) && $stable(stat_inc))
    else $error("stat entry changed while stalled");

endmodule

// File: hw/stat_pkg.sv
package stat_pkg;

    localparam int STAT_INC_WIDTH = 24;
    localparam int STAT_CNT_WIDTH = 32;

    localparam int STAT_CH_COUNT = 3;
    localparam int STAT_CH_WIDTH = 2;
    localparam int STAT_IDX_COUNT = 3;
    localparam int STAT_IDX_WIDTH = 2;
    // Id is channel times four plus index
    localparam int STAT_ID_WIDTH = STAT_CH_WIDTH + STAT_IDX_WIDTH;

    localparam logic [STAT_IDX_WIDTH-1:0] STAT_IDX_TLPS = 2'd0;
    localparam logic [STAT_IDX_WIDTH-1:0] STAT_IDX_DWORDS = 2'd1;
    localparam logic [STAT_IDX_WIDTH-1:0] STAT_IDX_AUX = 2'd2;

    localparam logic [STAT_CH_WIDTH-1:0] CH_RX_REQ = 2'd0;
    localparam logic [STAT_CH_WIDTH-1:0] CH_TX_RD_REQ = 2'd1;
    localparam logic [STAT_CH_WIDTH-1:0] CH_RX_CPL = 2'd2;

    localparam int WB_ADDR_WIDTH = 5;
    localparam int WB_DATA_WIDTH = 32;

    // Register map, word addresses
    localparam logic [WB_ADDR_WIDTH-1:0] REG_CTRL = 5'd0;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_CNT_BASE = 5'd16;
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_CLEAR_BIT = 1;

endpackage

// File: hw/stat_wb_regs.sv
module stat_wb_regs (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [stat_pkg::WB_ADDR_WIDTH-1:0]   wb_adr,
    input  logic [stat_pkg::WB_DATA_WIDTH-1:0]   wb_dat_w,
    input  logic                                 wb_we,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    output logic [stat_pkg::WB_DATA_WIDTH-1:0]   wb_dat_r,
    output logic                                 wb_ack,
    output logic                                 cnt_enable,
    output logic                                 cnt_clear,
    output logic [stat_pkg::STAT_ID_WIDTH-1:0]   rd_id,
    input  logic [stat_pkg::STAT_CNT_WIDTH-1:0]  rd_data
);
    import stat_pkg::*;

    logic                     wb_access;
    logic                     ctrl_sel;
    logic                     cnt_sel;
    logic [WB_DATA_WIDTH-1:0] rd_mux;

    // First cycle of a strobe, ack follows one cycle later
    assign wb_access = wb_cyc && wb_stb && !wb_ack;

    assign ctrl_sel = (wb_adr == REG_CTRL);
    assign cnt_sel = (wb_adr >= REG_CNT_BASE);
    assign rd_id = STAT_ID_WIDTH'(wb_adr - REG_CNT_BASE);

    always_comb begin
        rd_mux = '0;
        if (ctrl_sel) begin
            // Clear bit always reads back zero
            rd_mux[CTRL_ENABLE_BIT] = cnt_enable;
        end else if (cnt_sel) begin
            rd_mux = WB_DATA_WIDTH'(rd_data);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            cnt_enable <= 1'b1;
            cnt_clear <= 1'b0;
        end else begin
            wb_ack <= wb_access;
            cnt_clear <= 1'b0;
            // Writes into the counter window are dropped
            if (wb_access && wb_we && ctrl_sel) begin
                cnt_enable <= wb_dat_w[CTRL_ENABLE_BIT];
                cnt_clear <= wb_dat_w[CTRL_CLEAR_BIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_access) begin
            wb_dat_r <= rd_mux;
        end
    end

    assert property (@(posedge clk) disable iff (reset) wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack without a preceding strobe");

endmodule

// File: hw/tlp_pkg.sv
package tlp_pkg;

    localparam int TLP_HDR_WIDTH = 128;
    localparam int TLP_DW_WIDTH = 32;

    // Dword 0 occupies the top of the header, dword 1 sits below it
    localparam int TLP_DW0_LSB = 96;
    localparam int TLP_DW1_LSB = 64;

    // Field positions inside dword 0
    localparam int TLP_FMT_LSB = 29;
    localparam int TLP_FMT_WIDTH = 3;
    localparam int TLP_LEN_LSB = 0;
    localparam int TLP_LEN_WIDTH = 10;
    localparam int TLP_FMT_DATA_BIT = 1;

    // Format codes
    localparam logic [TLP_FMT_WIDTH-1:0] TLP_FMT_3DW = 3'b000;
    localparam logic [TLP_FMT_WIDTH-1:0] TLP_FMT_4DW = 3'b001;
    localparam logic [TLP_FMT_WIDTH-1:0] TLP_FMT_3DW_DATA = 3'b010;
    localparam logic [TLP_FMT_WIDTH-1:0] TLP_FMT_4DW_DATA = 3'b011;

    // Completion status codes
    localparam logic [2:0] CPL_STATUS_SC = 3'b000;
    localparam logic [2:0] CPL_STATUS_UR = 3'b001;
    localparam logic [2:0] CPL_STATUS_CRS = 3'b010;
    localparam logic [2:0] CPL_STATUS_CA = 3'b100;

    // Dword 1 reads differently for requests and completions
    typedef union packed {
        struct packed {
            logic [15:0] requester_id;
            logic [7:0]  tag;
            logic [3:0]  last_be;
            logic [3:0]  first_be;
        } req;
        struct packed {
            logic [15:0] completer_id;
            logic [2:0]  status;
            logic        bcm;
            logic [11:0] byte_count;
        } cpl;
    } tlp_dw1_u;

endpackage

// File: hw/tlp_stat_monitor.sv
module tlp_stat_monitor #(
    parameter bit IS_CPL = 1'b0
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [tlp_pkg::TLP_HDR_WIDTH-1:0]    tlp_hdr,
    input  logic                                 tlp_valid,
    input  logic                                 tlp_sop,
    input  logic                                 tlp_ready,
    output logic [stat_pkg::STAT_IDX_WIDTH-1:0]  stat_idx,
    output logic [stat_pkg::STAT_INC_WIDTH-1:0]  stat_inc,
    output logic                                 stat_valid,
    input  logic                                 stat_ready
);
    import tlp_pkg::*;
    import stat_pkg::*;

    logic [TLP_DW_WIDTH-1:0]   dw0;
    tlp_dw1_u                  dw1;
    logic [TLP_FMT_WIDTH-1:0]  fmt;
    logic [TLP_LEN_WIDTH-1:0]  len_field;
    logic [TLP_LEN_WIDTH:0]    len_dw;
    logic                      has_data;
    logic                      accept;
    logic [STAT_INC_WIDTH-1:0] aux_inc;

    logic [STAT_INC_WIDTH-1:0] stage_inc [STAT_IDX_COUNT];
    logic [STAT_INC_WIDTH-1:0] pending [STAT_IDX_COUNT];
    logic [STAT_INC_WIDTH:0]   pending_sum [STAT_IDX_COUNT];
    logic [STAT_IDX_WIDTH-1:0] sel_idx;
    logic                      sel_any;
    logic                      slot_free;
    logic                      slot_load;

    assign dw0 = tlp_hdr[TLP_DW0_LSB +: TLP_DW_WIDTH];
    assign dw1 = tlp_hdr[TLP_DW1_LSB +: TLP_DW_WIDTH];
    assign fmt = dw0[TLP_FMT_LSB +: TLP_FMT_WIDTH];
    assign len_field = dw0[TLP_LEN_LSB +: TLP_LEN_WIDTH];
    // Zero length field encodes the maximum of 1024 dwords
    assign len_dw = (len_field == '0) ? {1'b1, {TLP_LEN_WIDTH{1'b0}}} : {1'b0, len_field};
    assign has_data = fmt[TLP_FMT_DATA_BIT];
    assign accept = tlp_valid && tlp_ready && tlp_sop;

    always_comb begin
        if (IS_CPL) begin
            aux_inc = STAT_INC_WIDTH'(dw1.cpl.status != CPL_STATUS_SC);
        end else begin
            // Dwords asked for by read requests
            aux_inc = has_data ? '0 : STAT_INC_WIDTH'(len_dw);
        end
    end

    // Lowest nonzero pending index goes out first
    always_comb begin
        sel_any = 1'b0;
        sel_idx = '0;
        for (int i = STAT_IDX_COUNT - 1; i >= 0; i--) begin
            if (pending[i] != '0) begin
                sel_any = 1'b1;
                sel_idx = STAT_IDX_WIDTH'(i);
            end
        end
        for (int i = 0; i < STAT_IDX_COUNT; i++) begin
            pending_sum[i] = {1'b0, pending[i]} + {1'b0, stage_inc[i]};
        end
    end

    assign slot_free = !stat_valid || stat_ready;
    assign slot_load = slot_free && sel_any;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < STAT_IDX_COUNT; i++) begin
                stage_inc[i] <= '0;
                pending[i] <= '0;
            end
            stat_valid <= 1'b0;
        end else begin
            stage_inc[STAT_IDX_TLPS] <= STAT_INC_WIDTH'(accept);
            stage_inc[STAT_IDX_DWORDS] <= (accept && has_data) ? STAT_INC_WIDTH'(len_dw) : '0;
            stage_inc[STAT_IDX_AUX] <= accept ? aux_inc : '0;
            for (int i = 0; i < STAT_IDX_COUNT; i++) begin
                if (slot_load && sel_idx == STAT_IDX_WIDTH'(i)) begin
                    // Sum moved to the output slot, restart from this cycle's increment
                    pending[i] <= stage_inc[i];
                end else if (pending_sum[i][STAT_INC_WIDTH]) begin
                    pending[i] <= '1;
                end else begin
                    pending[i] <= pending_sum[i][STAT_INC_WIDTH-1:0];
                end
            end
            if (slot_free) begin
                stat_valid <= sel_any;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot_load) begin
            stat_idx <= sel_idx;
            stat_inc <= pending[sel_idx];
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        stat_valid && !stat_ready |=> stat_valid && $stable(stat_idx) && $stable(stat_inc))
    else $error("stat entry changed while stalled");

endmodule

// File: hw/tlp_stats_top.sv
module tlp_stats_top (
    input  logic                                 clk,
    input  logic                                 reset,

    input  logic [tlp_pkg::TLP_HDR_WIDTH-1:0]    rx_req_tlp_hdr,
    input  logic                                 rx_req_tlp_valid,
    input  logic                                 rx_req_tlp_sop,
    input  logic                                 rx_req_tlp_ready,

    input  logic [tlp_pkg::TLP_HDR_WIDTH-1:0]    tx_rd_req_tlp_hdr,
    input  logic                                 tx_rd_req_tlp_valid,
    input  logic                                 tx_rd_req_tlp_sop,
    input  logic                                 tx_rd_req_tlp_ready,

    input  logic [tlp_pkg::TLP_HDR_WIDTH-1:0]    rx_cpl_tlp_hdr,
    input  logic                                 rx_cpl_tlp_valid,
    input  logic                                 rx_cpl_tlp_sop,
    input  logic                                 rx_cpl_tlp_ready,

    input  logic [stat_pkg::WB_ADDR_WIDTH-1:0]   wb_adr,
    input  logic [stat_pkg::WB_DATA_WIDTH-1:0]   wb_dat_w,
    input  logic                                 wb_we,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    output logic [stat_pkg::WB_DATA_WIDTH-1:0]   wb_dat_r,
    output logic                                 wb_ack
);
    import stat_pkg::*;

    logic [STAT_IDX_WIDTH-1:0] mon_idx [STAT_CH_COUNT];
    logic [STAT_INC_WIDTH-1:0] mon_inc [STAT_CH_COUNT];
    logic [STAT_CH_COUNT-1:0]  mon_valid;
    logic [STAT_CH_COUNT-1:0]  mon_ready;

    logic [STAT_ID_WIDTH-1:0]  arb_id;
    logic [STAT_INC_WIDTH-1:0] arb_inc;
    logic                      arb_valid;
    logic                      arb_ready;

    logic                      cnt_enable;
    logic                      cnt_clear;
    logic [STAT_ID_WIDTH-1:0]  rd_id;
    logic [STAT_CNT_WIDTH-1:0] rd_data;

    // Requests received at the BAR
    tlp_stat_monitor #(.IS_CPL(1'b0)) rx_req_mon (
        .clk(clk), .reset(reset),
        .tlp_hdr(rx_req_tlp_hdr), .tlp_valid(rx_req_tlp_valid),
        .tlp_sop(rx_req_tlp_sop), .tlp_ready(rx_req_tlp_ready),
        .stat_idx(mon_idx[CH_RX_REQ]), .stat_inc(mon_inc[CH_RX_REQ]),
        .stat_valid(mon_valid[CH_RX_REQ]), .stat_ready(mon_ready[CH_RX_REQ])
    );

    // Read requests issued by the DMA engine
    tlp_stat_monitor #(.IS_CPL(1'b0)) tx_rd_req_mon (
        .clk(clk), .reset(reset),
        .tlp_hdr(tx_rd_req_tlp_hdr), .tlp_valid(tx_rd_req_tlp_valid),
        .tlp_sop(tx_rd_req_tlp_sop), .tlp_ready(tx_rd_req_tlp_ready),
        .stat_idx(mon_idx[CH_TX_RD_REQ]), .stat_inc(mon_inc[CH_TX_RD_REQ]),
        .stat_valid(mon_valid[CH_TX_RD_REQ]), .stat_ready(mon_ready[CH_TX_RD_REQ])
    );

    tlp_stat_monitor #(.IS_CPL(1'b1)) rx_cpl_mon (
        .clk(clk), .reset(reset),
        .tlp_hdr(rx_cpl_tlp_hdr), .tlp_valid(rx_cpl_tlp_valid),
        .tlp_sop(rx_cpl_tlp_sop), .tlp_ready(rx_cpl_tlp_ready),
        .stat_idx(mon_idx[CH_RX_CPL]), .stat_inc(mon_inc[CH_RX_CPL]),
        .stat_valid(mon_valid[CH_RX_CPL]), .stat_ready(mon_ready[CH_RX_CPL])
    );

    stat_arb_mux arb (
        .clk(clk), .reset(reset),
        .in_idx(mon_idx), .in_inc(mon_inc), .in_valid(mon_valid), .in_ready(mon_ready),
        .stat_id(arb_id), .stat_inc(arb_inc), .stat_valid(arb_valid), .stat_ready(arb_ready)
    );

    stat_counter_bank bank (
        .clk(clk), .reset(reset),
        .stat_id(arb_id), .stat_inc(arb_inc), .stat_valid(arb_valid), .stat_ready(arb_ready),
        .cnt_enable(cnt_enable), .cnt_clear(cnt_clear),
        .rd_id(rd_id), .rd_data(rd_data)
    );

    stat_wb_regs regs (
        .clk(clk), .reset(reset),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_we(wb_we),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .cnt_enable(cnt_enable), .cnt_clear(cnt_clear),
        .rd_id(rd_id), .rd_data(rd_data)
    );

endmodule

// File: run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_tlp_stats -f filelist.f
./obj_dir/Vtb_tlp_stats 2>&1 | tee sim.log
if grep -q "sim failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// File: test/tb_tlp_stats.sv
module tb_tlp_stats;
    import tlp_pkg::*;
    import stat_pkg::*;

    localparam int NUM_IDS = STAT_CH_COUNT * 4;
    localparam int WB_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 200;

    logic                      clk;
    logic                      reset;
    logic [TLP_HDR_WIDTH-1:0]  ch_hdr [STAT_CH_COUNT];
    logic [STAT_CH_COUNT-1:0]  ch_valid;
    logic [STAT_CH_COUNT-1:0]  ch_sop;
    logic [STAT_CH_COUNT-1:0]  ch_ready;
    logic [WB_ADDR_WIDTH-1:0]  wb_adr;
    logic [WB_DATA_WIDTH-1:0]  wb_dat_w;
    logic                      wb_we;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic [WB_DATA_WIDTH-1:0]  wb_dat_r;
    logic                      wb_ack;

    integer                    seed = 80778;
    logic                      traffic_on;
    int                        cycle;
    int                        check_count;
    int                        error_count;
    int                        timeout_count;
    logic [STAT_CNT_WIDTH-1:0] exp_cnt [NUM_IDS];
    logic [WB_DATA_WIDTH-1:0]  rd_val;

    tlp_stats_top dut0 (
        .clk(clk), .reset(reset),
        .rx_req_tlp_hdr(ch_hdr[CH_RX_REQ]), .rx_req_tlp_valid(ch_valid[CH_RX_REQ]),
        .rx_req_tlp_sop(ch_sop[CH_RX_REQ]), .rx_req_tlp_ready(ch_ready[CH_RX_REQ]),
        .tx_rd_req_tlp_hdr(ch_hdr[CH_TX_RD_REQ]), .tx_rd_req_tlp_valid(ch_valid[CH_TX_RD_REQ]),
        .tx_rd_req_tlp_sop(ch_sop[CH_TX_RD_REQ]), .tx_rd_req_tlp_ready(ch_ready[CH_TX_RD_REQ]),
        .rx_cpl_tlp_hdr(ch_hdr[CH_RX_CPL]), .rx_cpl_tlp_valid(ch_valid[CH_RX_CPL]),
        .rx_cpl_tlp_sop(ch_sop[CH_RX_CPL]), .rx_cpl_tlp_ready(ch_ready[CH_RX_CPL]),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_we(wb_we),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
    end

    function automatic logic [WB_ADDR_WIDTH-1:0] cnt_addr(input int id);
        return WB_ADDR_WIDTH'(int'(REG_CNT_BASE) + id);
    endfunction

    function automatic logic [TLP_HDR_WIDTH-1:0] random_hdr(input int c);
        logic [TLP_HDR_WIDTH-1:0] hdr;
        logic [31:0]              dw0;
        tlp_dw1_u                 dw1;
        logic [31:0]              rnd;
        hdr = {$random(seed), $random(seed), $random(seed), $random(seed)};
        dw0 = hdr[TLP_DW0_LSB +: 32];
        dw1 = hdr[TLP_DW1_LSB +: 32];
        rnd = $random(seed);
        case (rnd[1:0])
            2'd0: dw0[TLP_FMT_LSB +: TLP_FMT_WIDTH] = TLP_FMT_3DW;
            2'd1: dw0[TLP_FMT_LSB +: TLP_FMT_WIDTH] = TLP_FMT_4DW;
            2'd2: dw0[TLP_FMT_LSB +: TLP_FMT_WIDTH] = TLP_FMT_3DW_DATA;
            default: dw0[TLP_FMT_LSB +: TLP_FMT_WIDTH] = TLP_FMT_4DW_DATA;
        endcase
        // Zero length field for 1024 dwords about one time in eight
        if (rnd[4:2] == 3'd0) begin
            dw0[TLP_LEN_LSB +: TLP_LEN_WIDTH] = '0;
        end
        if (c == int'(CH_RX_CPL)) begin
            case (rnd[7:5])
                3'd5: dw1.cpl.status = CPL_STATUS_UR;
                3'd6: dw1.cpl.status = CPL_STATUS_CRS;
                3'd7: dw1.cpl.status = CPL_STATUS_CA;
                default: dw1.cpl.status = CPL_STATUS_SC;
            endcase
        end
        hdr[TLP_DW0_LSB +: 32] = dw0;
        hdr[TLP_DW1_LSB +: 32] = dw1;
        return hdr;
    endfunction

    // Random traffic on all three channels
    always @(posedge clk) begin
        bit run;
        run = traffic_on;
        #1;
        for (int c = 0; c < STAT_CH_COUNT; c++) begin
            if (run) begin
                ch_hdr[c] = random_hdr(c);
                ch_valid[c] = (($random(seed) & 7) < 5);
                ch_sop[c] = (($random(seed) & 3) != 0);
                ch_ready[c] = (($random(seed) & 3) != 0);
            end else begin
                ch_valid[c] = 1'b0;
                ch_sop[c] = 1'b0;
                ch_ready[c] = 1'b1;
            end
        end
    end

    task automatic count_tlp(input int c, input logic [TLP_HDR_WIDTH-1:0] hdr);
        logic [31:0]              dw0;
        tlp_dw1_u                 dw1;
        logic [TLP_FMT_WIDTH-1:0] fmt;
        logic [TLP_LEN_WIDTH-1:0] len_field;
        logic [31:0]              len;
        int                       base;
        dw0 = hdr[TLP_DW0_LSB +: 32];
        dw1 = hdr[TLP_DW1_LSB +: 32];
        fmt = dw0[TLP_FMT_LSB +: TLP_FMT_WIDTH];
        len_field = dw0[TLP_LEN_LSB +: TLP_LEN_WIDTH];
        len = (len_field == '0) ? 32'd1024 : {22'd0, len_field};
        base = c * 4;
        exp_cnt[base] = exp_cnt[base] + 32'd1;
        if (fmt[TLP_FMT_DATA_BIT]) begin
            exp_cnt[base + 1] = exp_cnt[base + 1] + len;
        end
        if (c == int'(CH_RX_CPL)) begin
            if (dw1.cpl.status != CPL_STATUS_SC) begin
                exp_cnt[base + 2] = exp_cnt[base + 2] + 32'd1;
            end
        end else if (!fmt[TLP_FMT_DATA_BIT]) begin
            exp_cnt[base + 2] = exp_cnt[base + 2] + len;
        end
    endtask

    // Reference model sees the same accepted headers as the monitors
    always @(posedge clk) begin
        if (reset) begin
            for (int id = 0; id < NUM_IDS; id++) begin
                exp_cnt[id] = '0;
            end
        end else begin
            for (int c = 0; c < STAT_CH_COUNT; c++) begin
                if (ch_valid[c] && ch_ready[c] && ch_sop[c]) begin
                    count_tlp(c, ch_hdr[c]);
                end
            end
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERROR %s expected 0x%08h got 0x%08h", name, exp, got);
            error_count++;
        end
    endtask

    task automatic wb_cycle(input logic [WB_ADDR_WIDTH-1:0] adr, input logic we,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        wb_adr = adr;
        wb_dat_w = wdata;
        wb_we = we;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < WB_TIMEOUT);
        rdata = wb_dat_r;
        if (!wb_ack) begin
            $display("Timeout waiting for Wishbone ack at address 0x%02h", adr);
            timeout_count++;
        end else begin
            // Ack comes on the cycle after the strobe is first seen
            check_value("wb_ack cycles after strobe", 32'(waited), 32'd1);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        idle_cycles(1);
        check_value("wb_ack after strobe dropped", {31'd0, wb_ack}, 32'd0);
    endtask

    task automatic wb_read(input logic [WB_ADDR_WIDTH-1:0] adr, output logic [31:0] data);
        wb_cycle(adr, 1'b0, 32'h0, data);
    endtask

    task automatic wb_write(input logic [WB_ADDR_WIDTH-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_cycle(adr, 1'b1, data, unused);
    endtask

    // Poll until the bank catches up with the model and then check every id
    task automatic drain_and_check();
        int          start;
        bit          settled;
        logic [31:0] got;
        start = cycle;
        settled = 1'b0;
        while (!settled && (cycle - start) < DRAIN_TIMEOUT) begin
            settled = 1'b1;
            for (int id = 0; id < NUM_IDS; id++) begin
                wb_read(cnt_addr(id), got);
                if (got !== exp_cnt[id]) begin
                    settled = 1'b0;
                end
            end
        end
        if (!settled) begin
            $display("Timeout: counters did not reach the model within %0d cycles",
                     DRAIN_TIMEOUT);
            timeout_count++;
        end
        for (int id = 0; id < NUM_IDS; id++) begin
            wb_read(cnt_addr(id), got);
            check_value($sformatf("wb_dat_r counter[%0d]", id), got, exp_cnt[id]);
        end
    endtask

    task automatic check_frozen();
        logic [31:0] first [NUM_IDS];
        logic [31:0] got;
        for (int id = 0; id < NUM_IDS; id++) begin
            wb_read(cnt_addr(id), first[id]);
        end
        idle_cycles(30);
        for (int id = 0; id < NUM_IDS; id++) begin
            wb_read(cnt_addr(id), got);
            check_value($sformatf("wb_dat_r frozen counter[%0d]", id), got, first[id]);
        end
    endtask

    initial begin
        reset = 1'b1;
        traffic_on = 1'b0;
        check_count = 0;
        error_count = 0;
        timeout_count = 0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_we = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        ch_valid = '0;
        ch_sop = '0;
        ch_ready = '1;
        for (int c = 0; c < STAT_CH_COUNT; c++) begin
            ch_hdr[c] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        idle_cycles(2);

        // Reset values
        wb_read(REG_CTRL, rd_val);
        check_value("wb_dat_r ctrl", rd_val, 32'h1);
        for (int id = 0; id < NUM_IDS; id++) begin
            wb_read(cnt_addr(id), rd_val);
            check_value($sformatf("wb_dat_r counter[%0d]", id), rd_val, 32'h0);
        end

        // Free-running traffic
        traffic_on = 1'b1;
        idle_cycles(300);
        traffic_on = 1'b0;
        idle_cycles(4);
        drain_and_check();

        // Freeze while traffic keeps coming and release afterwards
        traffic_on = 1'b1;
        wb_write(REG_CTRL, 32'h0);
        idle_cycles(4);
        wb_read(REG_CTRL, rd_val);
        check_value("wb_dat_r ctrl", rd_val, 32'h0);
        check_frozen();
        wb_write(REG_CTRL, 32'h1);
        idle_cycles(100);
        traffic_on = 1'b0;
        idle_cycles(4);
        drain_and_check();

        // Clear with enable kept set
        wb_write(REG_CTRL, 32'h3);
        for (int id = 0; id < NUM_IDS; id++) begin
            exp_cnt[id] = '0;
        end
        wb_read(REG_CTRL, rd_val);
        check_value("wb_dat_r ctrl", rd_val, 32'h1);
        drain_and_check();

        // Counting restarts from zero
        traffic_on = 1'b1;
        idle_cycles(200);
        traffic_on = 1'b0;
        idle_cycles(4);
        drain_and_check();

        $display("checks: %0d  errors: %0d  timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
